// ==== hw/hps_proto_pkg.sv ====
// Host protocol definitions

package hps_proto_pkg;

	// one word on the host bus
	typedef logic [15:0] host_word_t;

	// position of a word within a frame, saturates at all ones
	typedef logic [9:0] word_idx_t;

	//////////////////////////////////////////////////////////////////////
	// command codes, sent as word 0 of a frame
	//////////////////////////////////////////////////////////////////////

	// core settings
	localparam host_word_t CMD_CFG         = 16'h0001;
	localparam host_word_t CMD_JOY0        = 16'h0002;
	localparam host_word_t CMD_JOY1        = 16'h0003;
	localparam host_word_t CMD_STATUS      = 16'h001E;
	localparam host_word_t CMD_STATUS_REQ  = 16'h0029;
	localparam host_word_t CMD_MENUMASK    = 16'h002E;

	// file download
	localparam host_word_t CMD_FILE_TX     = 16'h0053;
	localparam host_word_t CMD_FILE_TX_DAT = 16'h0054;
	localparam host_word_t CMD_FILE_INDEX  = 16'h0055;
	localparam host_word_t CMD_FILE_INFO   = 16'h0056;

	// marks the status request reply, sits above the event counter
	localparam logic [3:0] STATUS_REQ_TAG  = 4'hA;

endpackage

// ==== hw/core_io_pkg.sv ====
// Core side data types

package core_io_pkg;

	// joystick buttons and directions
	typedef logic [31:0] joy_word_t;

	// core status register, written in four quarters
	typedef logic [63:0] status_word_t;

	// configuration word from the host menu
	typedef logic [15:0] cfg_word_t;

	// download byte address
	typedef logic [26:0] ioctl_addr_t;

	// file extension, four ascii characters
	typedef logic [31:0] file_ext_t;

	// menu index of the file being sent
	typedef logic [7:0] file_index_t;

	// counts status_set requests from the core
	typedef logic [3:0] st_count_t;

endpackage

// ==== hw/host_cmd_if.sv ====
// Framed host command stream

`timescale 1ns/1ps

interface host_cmd_if;

	import hps_proto_pkg::*;

	// frame open
	logic       active;
	// word present this cycle
	logic       strobe;
	host_word_t word;
	// position of word in frame, 0 is the command word
	word_idx_t  idx;
	// command from word 0, valid once idx is 1 or more
	host_word_t cmd;

	modport framer (
		output active,
		output strobe,
		output word,
		output idx,
		output cmd
	);

	modport handler (
		input active,
		input strobe,
		input word,
		input idx,
		input cmd
	);

endinterface

// ==== hw/host_cmd_framer.sv ====
// Host command framer

`timescale 1ns/1ps

module host_cmd_framer (
	input  logic                     clk_sys,
	input  logic                     reset,
	input  logic                     host_enable,
	input  logic                     host_strobe,
	input  hps_proto_pkg::host_word_t host_din,
	host_cmd_if.framer               cmd_bus
);

	// word and strobe go straight through, handlers register them
	assign cmd_bus.active = host_enable;
	assign cmd_bus.strobe = host_enable & host_strobe;
	assign cmd_bus.word   = host_din;

	//////////////////////////////////////////////////////////////////////
	// word index and command latch
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cmd_bus.idx <= '0;
			cmd_bus.cmd <= '0;
		end else if (!host_enable) begin
			// frame closed, get ready for the next command word
			cmd_bus.idx <= '0;
			cmd_bus.cmd <= '0;
		end else if (host_strobe) begin
			if (cmd_bus.idx != '1) begin
				cmd_bus.idx <= cmd_bus.idx + 1'b1;
			end
			if (cmd_bus.idx == '0) begin
				cmd_bus.cmd <= host_din;
			end
		end
	end

endmodule

// ==== hw/core_reg_handler.sv ====
// Core settings register handler

`timescale 1ns/1ps

module core_reg_handler (
	input  logic                        clk_sys,
	input  logic                        reset,
	host_cmd_if.handler                 cmd_bus,
	input  core_io_pkg::status_word_t   status_in,
	input  logic                        status_set,
	input  hps_proto_pkg::host_word_t   status_menumask,
	output core_io_pkg::cfg_word_t      cfg,
	output core_io_pkg::joy_word_t      joystick_0,
	output core_io_pkg::joy_word_t      joystick_1,
	output core_io_pkg::status_word_t   status,
	output hps_proto_pkg::host_word_t   reply
);

	import hps_proto_pkg::*;
	import core_io_pkg::*;

	logic         status_set_q;
	st_count_t    st_count;
	status_word_t status_req;

	//////////////////////////////////////////////////////////////////////
	// status set requests from the core
	//////////////////////////////////////////////////////////////////////

	// each rising edge snapshots status_in and bumps the counter
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			status_set_q <= 1'b0;
			st_count     <= '0;
			status_req   <= '0;
		end else begin
			status_set_q <= status_set;
			if (status_set && !status_set_q) begin
				st_count   <= st_count + 1'b1;
				status_req <= status_in;
			end
		end
	end

	//////////////////////////////////////////////////////////////////////
	// register writes and replies
	//////////////////////////////////////////////////////////////////////

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			cfg        <= '0;
			joystick_0 <= '0;
			joystick_1 <= '0;
			status     <= '0;
			reply      <= '0;
		end else if (!cmd_bus.active) begin
			reply <= '0;
		end else if (cmd_bus.strobe) begin
			reply <= '0;
			if (cmd_bus.idx == '0) begin
				// host polls the request counter with the command word itself
				if (cmd_bus.word == CMD_STATUS_REQ) begin
					reply <= {8'h00, STATUS_REQ_TAG, st_count};
				end
			end else begin
				case (cmd_bus.cmd)
					CMD_CFG: cfg <= cmd_bus.word;
					CMD_JOY0: begin
						if (cmd_bus.idx == 10'd1) begin
							joystick_0[15:0] <= cmd_bus.word;
						end else if (cmd_bus.idx == 10'd2) begin
							joystick_0[31:16] <= cmd_bus.word;
						end
					end
					CMD_JOY1: begin
						if (cmd_bus.idx == 10'd1) begin
							joystick_1[15:0] <= cmd_bus.word;
						end else if (cmd_bus.idx == 10'd2) begin
							joystick_1[31:16] <= cmd_bus.word;
						end
					end
					// low quarter first
					CMD_STATUS: begin
						case (cmd_bus.idx)
							10'd1: status[15:0]  <= cmd_bus.word;
							10'd2: status[31:16] <= cmd_bus.word;
							10'd3: status[47:32] <= cmd_bus.word;
							10'd4: status[63:48] <= cmd_bus.word;
							default: ;
						endcase
					end
					CMD_STATUS_REQ: begin
						case (cmd_bus.idx)
							10'd1: reply <= status_req[15:0];
							10'd2: reply <= status_req[31:16];
							10'd3: reply <= status_req[47:32];
							10'd4: reply <= status_req[63:48];
							default: ;
						endcase
					end
					CMD_MENUMASK: begin
						if (cmd_bus.idx == 10'd1) begin
							reply <= status_menumask;
						end
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== hw/file_download.sv ====
// File download into the core

`timescale 1ns/1ps

module file_download #(
	parameter int WIDE = 0
) (
	input  logic                       clk_sys,
	input  logic                       reset,
	host_cmd_if.handler                cmd_bus,
	output logic                       ioctl_download,
	output core_io_pkg::file_index_t   ioctl_index,
	output core_io_pkg::file_ext_t     ioctl_file_ext,
	output logic                       ioctl_wr,
	output core_io_pkg::ioctl_addr_t   ioctl_addr,
	output hps_proto_pkg::host_word_t  ioctl_dout
);

	import hps_proto_pkg::*;
	import core_io_pkg::*;

	// byte mode keeps only the low half of each data word
	localparam host_word_t  DATA_MASK = (WIDE != 0) ? 16'hFFFF : 16'h00FF;
	localparam ioctl_addr_t ADDR_STEP = (WIDE != 0) ? 27'd2 : 27'd1;

	// write strobe one cycle ahead of ioctl_wr
	logic        wr_pend;
	// address of the next data word
	ioctl_addr_t addr;

	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			wr_pend        <= 1'b0;
			ioctl_wr       <= 1'b0;
			ioctl_download <= 1'b0;
			ioctl_index    <= '0;
			ioctl_file_ext <= '0;
			ioctl_addr     <= '0;
			ioctl_dout     <= '0;
			addr           <= '0;
		end else begin
			ioctl_wr <= wr_pend;
			wr_pend  <= 1'b0;
			if (cmd_bus.strobe && cmd_bus.idx != '0) begin
				case (cmd_bus.cmd)
					// high half of the extension comes first
					CMD_FILE_INFO: begin
						if (cmd_bus.idx == 10'd1) begin
							ioctl_file_ext[31:16] <= cmd_bus.word;
						end else if (cmd_bus.idx == 10'd2) begin
							ioctl_file_ext[15:0] <= cmd_bus.word;
						end
					end
					CMD_FILE_INDEX: ioctl_index <= cmd_bus.word[7:0];
					CMD_FILE_TX: begin
						if (cmd_bus.word[7:0] != 8'h00) begin
							addr           <= '0;
							ioctl_download <= 1'b1;
						end else begin
							// final address tells the core the file size
							ioctl_addr     <= addr;
							ioctl_download <= 1'b0;
						end
					end
					CMD_FILE_TX_DAT: begin
						ioctl_addr <= addr;
						ioctl_dout <= cmd_bus.word & DATA_MASK;
						wr_pend    <= 1'b1;
						addr       <= addr + ADDR_STEP;
					end
					default: ;
				endcase
			end
		end
	end

endmodule

// ==== hw/host_reply.sv ====
// Host reply combiner

`timescale 1ns/1ps

module host_reply (
	input  logic                      clk_sys,
	input  logic                      reset,
	input  logic                      host_enable,
	input  hps_proto_pkg::host_word_t reg_reply,
	input  hps_proto_pkg::host_word_t dl_reply,
	input  logic                      ioctl_wait,
	output hps_proto_pkg::host_word_t host_dout,
	output logic                      host_wait
);

	// silent handlers drive zero, so OR picks whichever one answers
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			host_dout <= '0;
		end else if (!host_enable) begin
			host_dout <= '0;
		end else begin
			host_dout <= reg_reply | dl_reply;
		end
	end

	// core back-pressure, one register stage towards the host
	always_ff @(posedge clk_sys or posedge reset) begin
		if (reset) begin
			host_wait <= 1'b0;
		end else begin
			host_wait <= ioctl_wait;
		end
	end

endmodule

// ==== hw/hps_link_top.sv ====
// Host command link top level

`timescale 1ns/1ps

module hps_link_top #(
	parameter int WIDE = 0
) (
	input  logic                      clk_sys,
	input  logic                      reset,

	// host bus
	input  logic                      host_enable,
	input  logic                      host_strobe,
	input  hps_proto_pkg::host_word_t host_din,
	output hps_proto_pkg::host_word_t host_dout,
	output logic                      host_wait,
	input  logic                      ioctl_wait,

	// core settings
	output logic [1:0]                buttons,
	output logic                      forced_scandoubler,
	output logic                      direct_video,
	output core_io_pkg::joy_word_t    joystick_0,
	output core_io_pkg::joy_word_t    joystick_1,
	output core_io_pkg::status_word_t status,
	input  core_io_pkg::status_word_t status_in,
	input  logic                      status_set,
	input  hps_proto_pkg::host_word_t status_menumask,

	// download
	output logic                      ioctl_download,
	output core_io_pkg::file_index_t  ioctl_index,
	output core_io_pkg::file_ext_t    ioctl_file_ext,
	output logic                      ioctl_wr,
	output core_io_pkg::ioctl_addr_t  ioctl_addr,
	output hps_proto_pkg::host_word_t ioctl_dout
);

	import hps_proto_pkg::*;
	import core_io_pkg::*;

	cfg_word_t  cfg;
	host_word_t reg_reply;
	host_word_t dl_reply;

	host_cmd_if cmd_bus ();

	// other cfg bits are used outside the core
	assign buttons            = cfg[1:0];
	assign forced_scandoubler = cfg[4];
	assign direct_video       = cfg[10];

	// download path has no read-back yet
	assign dl_reply = '0;

	host_cmd_framer u_framer (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host_enable (host_enable),
		.host_strobe (host_strobe),
		.host_din    (host_din),
		.cmd_bus     (cmd_bus.framer)
	);

	core_reg_handler u_regs (
		.clk_sys         (clk_sys),
		.reset           (reset),
		.cmd_bus         (cmd_bus.handler),
		.status_in       (status_in),
		.status_set      (status_set),
		.status_menumask (status_menumask),
		.cfg             (cfg),
		.joystick_0      (joystick_0),
		.joystick_1      (joystick_1),
		.status          (status),
		.reply           (reg_reply)
	);

	file_download #(
		.WIDE (WIDE)
	) u_download (
		.clk_sys        (clk_sys),
		.reset          (reset),
		.cmd_bus        (cmd_bus.handler),
		.ioctl_download (ioctl_download),
		.ioctl_index    (ioctl_index),
		.ioctl_file_ext (ioctl_file_ext),
		.ioctl_wr       (ioctl_wr),
		.ioctl_addr     (ioctl_addr),
		.ioctl_dout     (ioctl_dout)
	);

	host_reply u_reply (
		.clk_sys     (clk_sys),
		.reset       (reset),
		.host_enable (host_enable),
		.reg_reply   (reg_reply),
		.dl_reply    (dl_reply),
		.ioctl_wait  (ioctl_wait),
		.host_dout   (host_dout),
		.host_wait   (host_wait)
	);

endmodule

// ==== verif/hps_link_assertions.sv ====
// Host link protocol assertions

`timescale 1ns/1ps

module hps_link_assertions (
	input logic                      clk_sys,
	input logic                      reset,
	input logic                      host_enable,
	input logic                      host_strobe,
	input logic                      host_wait,
	input hps_proto_pkg::host_word_t host_dout,
	input logic                      ioctl_wr,
	input logic                      ioctl_download
);

	// number of failed assertions, summed into the testbench result
	int fail_count = 0;

	// write strobe towards the core is a single cycle pulse
	a_wr_single : assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |=> !ioctl_wr)
	else begin
		fail_count++;
		$error("ioctl_wr stayed high for more than one cycle");
	end

	a_wr_in_download : assert property (@(posedge clk_sys) disable iff (reset)
		ioctl_wr |-> ioctl_download)
	else begin
		fail_count++;
		$error("ioctl_wr pulsed outside a download");
	end

	// host must hold off while the core asks for a pause
	a_no_strobe_in_wait : assert property (@(posedge clk_sys) disable iff (reset)
		(host_enable && host_strobe) |-> !host_wait)
	else begin
		fail_count++;
		$error("host strobe arrived while host_wait was high");
	end

	a_dout_idle : assert property (@(posedge clk_sys) disable iff (reset)
		$fell(host_enable) |-> ##2 (host_dout == '0))
	else begin
		fail_count++;
		$error("host_dout not zero two cycles after the frame closed");
	end

endmodule

bind hps_link_top hps_link_assertions u_checks (
	.clk_sys        (clk_sys),
	.reset          (reset),
	.host_enable    (host_enable),
	.host_strobe    (host_strobe),
	.host_wait      (host_wait),
	.host_dout      (host_dout),
	.ioctl_wr       (ioctl_wr),
	.ioctl_download (ioctl_download)
);

// ==== verif/hps_link_tb.sv ====
// Host command link testbench

`timescale 1ns/1ps

module hps_link_tb;

	import hps_proto_pkg::*;
	import core_io_pkg::*;

	// longest frame is the command word and eight data words
	localparam int N_FRAMES       = 40;
	localparam int MAX_WORDS      = 9;
	localparam int FRAME_CYCLES   = MAX_WORDS * 4 + 6;
	localparam int TIMEOUT_CYCLES = N_FRAMES * FRAME_CYCLES + 200;

	logic         clk_sys = 1'b0;
	logic         reset;
	logic         host_enable;
	logic         host_strobe;
	host_word_t   host_din;
	host_word_t   host_dout;
	logic         host_wait;
	logic         ioctl_wait;
	logic [1:0]   buttons;
	logic         forced_scandoubler;
	logic         direct_video;
	joy_word_t    joystick_0;
	joy_word_t    joystick_1;
	status_word_t status;
	status_word_t status_in;
	logic         status_set;
	host_word_t   status_menumask;
	logic         ioctl_download;
	file_index_t  ioctl_index;
	file_ext_t    ioctl_file_ext;
	logic         ioctl_wr;
	ioctl_addr_t  ioctl_addr;
	host_word_t   ioctl_dout;

	// reference model of the core side
	cfg_word_t    exp_cfg = '0;
	joy_word_t    exp_joy0 = '0;
	joy_word_t    exp_joy1 = '0;
	status_word_t exp_status = '0;
	st_count_t    exp_count = '0;
	status_word_t exp_req = '0;
	file_index_t  exp_index = '0;
	file_ext_t    exp_ext = '0;
	logic         exp_download = 1'b0;
	ioctl_addr_t  exp_addr = '0;
	ioctl_addr_t  exp_pub_addr = '0;

	logic [31:0]  rng_state = 32'he420;
	int           errors = 0;
	int           checks = 0;
	int           test_errors = 0;
	int           cycles = 0;
	int           wr_pulses = 0;

	// words of the current frame starting with the command
	host_word_t   frame_words [0:15];
	host_word_t   frame_reps [0:15];
	logic         samp_wr [0:15];
	ioctl_addr_t  samp_addr [0:15];
	host_word_t   samp_dout [0:15];

	hps_link_top #(
		.WIDE (1)
	) uut (
		.clk_sys            (clk_sys),
		.reset              (reset),
		.host_enable        (host_enable),
		.host_strobe        (host_strobe),
		.host_din           (host_din),
		.host_dout          (host_dout),
		.host_wait          (host_wait),
		.ioctl_wait         (ioctl_wait),
		.buttons            (buttons),
		.forced_scandoubler (forced_scandoubler),
		.direct_video       (direct_video),
		.joystick_0         (joystick_0),
		.joystick_1         (joystick_1),
		.status             (status),
		.status_in          (status_in),
		.status_set         (status_set),
		.status_menumask    (status_menumask),
		.ioctl_download     (ioctl_download),
		.ioctl_index        (ioctl_index),
		.ioctl_file_ext     (ioctl_file_ext),
		.ioctl_wr           (ioctl_wr),
		.ioctl_addr         (ioctl_addr),
		.ioctl_dout         (ioctl_dout)
	);

	always #20 clk_sys = ~clk_sys;

	always @(posedge clk_sys) begin
		cycles <= cycles + 1;
		if (cycles >= TIMEOUT_CYCLES) begin
			$display("timeout, tests did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("TESTS FAILED");
			$finish;
		end
	end

	// count every write pulse the core sees
	always @(negedge clk_sys) begin
		if (ioctl_wr === 1'b1) begin
			wr_pulses = wr_pulses + 1;
		end
	end

	//////////////////////////////////////////////////////////////////////
	// helpers
	//////////////////////////////////////////////////////////////////////

	function automatic logic [31:0] xorshift32(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function logic [31:0] next_rand();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function host_word_t rand_word();
		logic [31:0] r;
		r = next_rand();
		return r[15:0];
	endfunction

	task check_val(input string name, input logic [63:0] got, input logic [63:0] exp);
		checks++;
		assert (got === exp) else begin
			errors++;
			$display("mismatch %s: got %h expected %h", name, got, exp);
		end
	endtask

	task end_test(input string name);
		$display("test %s: %0d errors", name, errors - test_errors);
		test_errors = errors;
	endtask

	// strobe one word then sample the reply and the core write 2 cycles on
	task send_word(input int i);
		@(posedge clk_sys);
		host_strobe <= 1'b1;
		host_din    <= frame_words[i];
		@(posedge clk_sys);
		host_strobe <= 1'b0;
		@(posedge clk_sys);
		@(negedge clk_sys);
		frame_reps[i] = host_dout;
		samp_wr[i]    = ioctl_wr;
		samp_addr[i]  = ioctl_addr;
		samp_dout[i]  = ioctl_dout;
		@(posedge clk_sys);
	endtask

	task run_frame(input int n);
		@(posedge clk_sys);
		host_enable <= 1'b1;
		for (int i = 0; i < n; i++) begin
			send_word(i);
		end
		host_enable <= 1'b0;
		repeat (3) @(posedge clk_sys);
	endtask

	task check_outputs();
		@(negedge clk_sys);
		check_val("buttons", buttons, exp_cfg[1:0]);
		check_val("forced_scandoubler", forced_scandoubler, exp_cfg[4]);
		check_val("direct_video", direct_video, exp_cfg[10]);
		check_val("joystick_0", joystick_0, exp_joy0);
		check_val("joystick_1", joystick_1, exp_joy1);
		check_val("status", status, exp_status);
		check_val("ioctl_download", ioctl_download, exp_download);
		check_val("ioctl_index", ioctl_index, exp_index);
		check_val("ioctl_file_ext", ioctl_file_ext, exp_ext);
		check_val("ioctl_addr", ioctl_addr, exp_pub_addr);
	endtask

	//////////////////////////////////////////////////////////////////////
	// test sequence
	//////////////////////////////////////////////////////////////////////

	initial begin
		int           n;
		int           pulses_before;
		host_word_t   mask;
		status_word_t st_val;

		reset           = 1'b1;
		host_enable     = 1'b0;
		host_strobe     = 1'b0;
		host_din        = '0;
		ioctl_wait      = 1'b0;
		status_in       = '0;
		status_set      = 1'b0;
		status_menumask = '0;
		repeat (4) @(posedge clk_sys);
		reset <= 1'b0;

		@(negedge clk_sys);
		check_val("host_dout", host_dout, 0);
		check_val("host_wait", host_wait, 0);
		check_val("ioctl_wr", ioctl_wr, 0);
		check_val("ioctl_download", ioctl_download, 0);
		end_test("reset");

		repeat (4) begin
			frame_words[0] = CMD_CFG;
			frame_words[1] = rand_word();
			run_frame(2);
			exp_cfg = frame_words[1];
			check_outputs();
		end
		end_test("cfg");

		repeat (4) begin
			frame_words[0] = CMD_JOY0;
			frame_words[1] = rand_word();
			frame_words[2] = rand_word();
			run_frame(3);
			exp_joy0 = {frame_words[2], frame_words[1]};
			frame_words[0] = CMD_JOY1;
			frame_words[1] = rand_word();
			frame_words[2] = rand_word();
			run_frame(3);
			exp_joy1 = {frame_words[2], frame_words[1]};
			frame_words[0] = CMD_STATUS;
			for (int i = 1; i <= 4; i++) begin
				frame_words[i] = rand_word();
			end
			run_frame(5);
			exp_status = {frame_words[4], frame_words[3], frame_words[2], frame_words[1]};
			check_outputs();
		end
		end_test("joystick and status");

		repeat (3) begin
			n = 1 + (next_rand() % 7);
			repeat (n) begin
				st_val = {next_rand(), next_rand()};
				@(posedge clk_sys);
				status_in  <= st_val;
				status_set <= 1'b1;
				// held for a few cycles so that only the rising edge may count
				repeat (1 + (next_rand() % 3)) @(posedge clk_sys);
				status_set <= 1'b0;
				exp_req   = st_val;
				exp_count = exp_count + 1'b1;
			end
			mask = rand_word();
			@(posedge clk_sys);
			status_menumask <= mask;
			frame_words[0] = CMD_STATUS_REQ;
			for (int i = 1; i <= 4; i++) begin
				frame_words[i] = rand_word();
			end
			run_frame(5);
			check_val("host_dout tag", frame_reps[0], 16'h00A0 + exp_count);
			for (int i = 1; i <= 4; i++) begin
				check_val($sformatf("host_dout quarter %0d", i), frame_reps[i],
					exp_req[16 * (i - 1) +: 16]);
			end
			frame_words[0] = CMD_MENUMASK;
			frame_words[1] = rand_word();
			run_frame(2);
			check_val("host_dout menumask", frame_reps[1], mask);
		end
		end_test("status request");

		frame_words[0] = CMD_FILE_INDEX;
		frame_words[1] = rand_word();
		run_frame(2);
		exp_index = frame_words[1][7:0];
		frame_words[0] = CMD_FILE_INFO;
		frame_words[1] = rand_word();
		frame_words[2] = rand_word();
		run_frame(3);
		exp_ext = {frame_words[1], frame_words[2]};
		// the second download has to restart the address at zero
		repeat (2) begin
			frame_words[0] = CMD_FILE_TX;
			frame_words[1] = rand_word() | 16'h0001;
			run_frame(2);
			exp_download = 1'b1;
			exp_addr     = '0;
			check_outputs();
			// 16-bit data words step the byte address by 2
			n = 3 + (next_rand() % 6);
			frame_words[0] = CMD_FILE_TX_DAT;
			for (int i = 1; i <= n; i++) begin
				frame_words[i] = rand_word();
			end
			pulses_before = wr_pulses;
			run_frame(n + 1);
			for (int i = 1; i <= n; i++) begin
				check_val($sformatf("ioctl_wr word %0d", i), samp_wr[i], 1);
				check_val($sformatf("ioctl_addr word %0d", i), samp_addr[i], exp_addr);
				check_val($sformatf("ioctl_dout word %0d", i), samp_dout[i],
					frame_words[i]);
				exp_addr = exp_addr + 27'd2;
			end
			check_val("ioctl_wr pulse count", wr_pulses - pulses_before, n);
			frame_words[0] = CMD_FILE_TX;
			frame_words[1] = rand_word() & 16'hFF00;
			run_frame(2);
			exp_download = 1'b0;
			exp_pub_addr = exp_addr;
			check_outputs();
		end
		end_test("download");

		@(posedge clk_sys);
		ioctl_wait <= 1'b1;
		@(negedge clk_sys);
		check_val("host_wait", host_wait, 0);
		@(negedge clk_sys);
		check_val("host_wait", host_wait, 1);
		@(posedge clk_sys);
		ioctl_wait <= 1'b0;
		@(negedge clk_sys);
		check_val("host_wait", host_wait, 1);
		@(negedge clk_sys);
		check_val("host_wait", host_wait, 0);
		end_test("wait");

		// no known command code has bit 15 set
		repeat (3) begin
			frame_words[0] = 16'h8000 | rand_word();
			for (int i = 1; i <= 3; i++) begin
				frame_words[i] = rand_word();
			end
			run_frame(4);
			for (int i = 0; i <= 3; i++) begin
				check_val($sformatf("host_dout word %0d", i), frame_reps[i], 0);
			end
			check_outputs();
		end
		end_test("unknown command");

		if (uut.u_checks.fail_count != 0) begin
			$display("bound protocol assertions failed %0d times", uut.u_checks.fail_count);
			errors = errors + uut.u_checks.fail_count;
		end
		$display("%0d checks, %0d errors", checks, errors);
		if (errors == 0) begin
			$display("TESTS PASSED");
		end else begin
			$display("TESTS FAILED");
		end
		$finish;
	end

endmodule

// ==== build.f ====
hw/hps_proto_pkg.sv
hw/core_io_pkg.sv
hw/host_cmd_if.sv
hw/host_cmd_framer.sv
hw/core_reg_handler.sv
hw/file_download.sv
hw/host_reply.sv
hw/hps_link_top.sv
verif/hps_link_assertions.sv
verif/hps_link_tb.sv

// ==== Bender.yml ====
package:
  name: hps_link

sources:
  - files:
      - hw/hps_proto_pkg.sv
      - hw/core_io_pkg.sv
      - hw/host_cmd_if.sv
      - hw/host_cmd_framer.sv
      - hw/core_reg_handler.sv
      - hw/file_download.sv
      - hw/host_reply.sv
      - hw/hps_link_top.sv
  - target: test
    files:
      - verif/hps_link_assertions.sv
      - verif/hps_link_tb.sv
